//--- bubbleEmuPkg.sv
`default_nettype none

package bubbleEmuPkg;

    // Widths with a meaning of their own
    typedef logic [10:0] pagePos;
    typedef logic [6:0]  nibbleIdx;
    typedef logic [5:0]  byteAddr;
    typedef logic [23:0] flashAddr;
    typedef logic [2:0]  imgSel;

    localparam int CLK_DIV      = 12;
    localparam int PAGE_COUNT   = 2048;
    localparam int PAGE_BYTES   = 64;
    localparam int NIBBLE_COUNT = 128;
    localparam int LOAD_WAIT    = 128;

    // Flash layout, one image every 256 KiB
    localparam flashAddr   IMAGE_STRIDE = 24'h04_0000;
    localparam flashAddr   BOOT_OFFSET  = 24'h02_0000;
    localparam logic [7:0] READ_CMD     = 8'h03;

    typedef enum logic [1:0] {
        accIdle = 2'd0,
        accLoad = 2'd1,
        accOut  = 2'd2
    } accState;

    typedef struct packed {
        accState  state;
        logic     boot;
        pagePos   absPos;
        nibbleIdx boutCycle;
        logic     boutEn;
        logic     start;
    } accCtrl;

    typedef struct packed {
        logic       en;
        byteAddr    addr;
        logic [7:0] data;
    } bufWrite;

endpackage

`default_nettype wire

//--- TimingGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module TimingGenerator (
    input  logic                 MCLK,
    input  logic                 rstN,
    input  logic                 nEn,
    input  logic                 nBss,
    input  logic                 nBsen,
    input  logic                 nBooten,
    output logic                 clkOut,
    output bubbleEmuPkg::accCtrl acc
);

    logic [3:0]             divCnt;
    logic                   tick;
    bubbleEmuPkg::nibbleIdx waitCnt;
    bubbleEmuPkg::accCtrl   ctrl;

    function automatic bubbleEmuPkg::accCtrl idleCtrl();
        bubbleEmuPkg::accCtrl c;
        c.state     = bubbleEmuPkg::accIdle;
        c.boot      = 1'b0;
        c.absPos    = '0;
        c.boutCycle = '0;
        c.boutEn    = 1'b0;
        c.start     = 1'b0;
        return c;
    endfunction

    // Tick is the MCLK edge where clkOut rises
    assign tick = !nEn && (divCnt == 4'(bubbleEmuPkg::CLK_DIV - 1));

    // 48 MHz down to 4 MHz, high for the first half of the period
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            divCnt <= '0;
            clkOut <= 1'b0;
        end else if (nEn) begin
            divCnt <= '0;
            clkOut <= 1'b0;
        end else if (tick) begin
            divCnt <= '0;
            clkOut <= 1'b1;
        end else begin
            divCnt <= divCnt + 4'd1;
            if (divCnt == 4'(bubbleEmuPkg::CLK_DIV / 2 - 1)) begin
                clkOut <= 1'b0;
            end
        end
    end

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            ctrl    <= idleCtrl();
            waitCnt <= '0;
        end else if (nEn) begin
            ctrl    <= idleCtrl();
            waitCnt <= '0;
        end else begin
            ctrl.start  <= 1'b0;
            ctrl.boutEn <= 1'b0;
            if (tick) begin
                case (ctrl.state)
                    bubbleEmuPkg::accIdle: begin
                        // Position only moves between accesses
                        if (!nBss) begin
                            if (ctrl.absPos == bubbleEmuPkg::pagePos'(bubbleEmuPkg::PAGE_COUNT - 1)) begin
                                ctrl.absPos <= '0;
                            end else begin
                                ctrl.absPos <= ctrl.absPos + 1'b1;
                            end
                        end
                        if (!nBsen) begin
                            ctrl.state <= bubbleEmuPkg::accLoad;
                            ctrl.start <= 1'b1;
                            ctrl.boot  <= !nBooten;
                            waitCnt    <= '0;
                        end
                    end
                    bubbleEmuPkg::accLoad: begin
                        // Give the loader time to fill the page buffer
                        if (waitCnt == bubbleEmuPkg::nibbleIdx'(bubbleEmuPkg::LOAD_WAIT - 1)) begin
                            ctrl.state     <= bubbleEmuPkg::accOut;
                            ctrl.boutEn    <= 1'b1;
                            ctrl.boutCycle <= '0;
                        end else begin
                            waitCnt <= waitCnt + 1'b1;
                        end
                    end
                    bubbleEmuPkg::accOut: begin
                        if (ctrl.boutCycle ==
                            bubbleEmuPkg::nibbleIdx'(bubbleEmuPkg::NIBBLE_COUNT - 1)) begin
                            ctrl.state <= bubbleEmuPkg::accIdle;
                        end else begin
                            ctrl.boutCycle <= ctrl.boutCycle + 1'b1;
                            ctrl.boutEn    <= 1'b1;
                        end
                    end
                    default: begin
                        ctrl.state <= bubbleEmuPkg::accIdle;
                    end
                endcase
            end
        end
    end

    assign acc = ctrl;

endmodule

`default_nettype wire

//--- SPILoader.sv
`timescale 1ns/1ps
`default_nettype none

module SPILoader (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  bubbleEmuPkg::imgSel   imgNum,
    input  bubbleEmuPkg::accCtrl  acc,
    output bubbleEmuPkg::bufWrite wr,
    output logic                  nCs,
    output logic                  mosi,
    output logic                  clk,
    input  logic                  miso
);

    typedef enum logic [1:0] {
        ldIdle,
        ldCmd,
        ldAddr,
        ldData
    } ldState;

    ldState                 state;
    bubbleEmuPkg::flashAddr startAddr;
    bubbleEmuPkg::flashAddr pageOffset;
    logic [31:0]            txReg;
    logic [7:0]             rxReg;
    logic [4:0]             bitCnt;
    bubbleEmuPkg::byteAddr  byteCnt;

    assign pageOffset = acc.boot ? bubbleEmuPkg::BOOT_OFFSET
                                 : bubbleEmuPkg::flashAddr'(acc.absPos) *
                                   bubbleEmuPkg::flashAddr'(bubbleEmuPkg::PAGE_BYTES);

    assign startAddr = bubbleEmuPkg::flashAddr'(imgNum) * bubbleEmuPkg::IMAGE_STRIDE
                     + pageOffset;

    // SPI mode 0 at MCLK/2, clk toggles every MCLK while busy
    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            state   <= ldIdle;
            nCs     <= 1'b1;
            mosi    <= 1'b0;
            clk     <= 1'b0;
            txReg   <= '0;
            rxReg   <= '0;
            bitCnt  <= '0;
            byteCnt <= '0;
            wr      <= '0;
        end else begin
            wr.en <= 1'b0;
            if (state != ldIdle && acc.state == bubbleEmuPkg::accIdle) begin
                // Access dropped, e.g. drive disabled mid-load
                state <= ldIdle;
                nCs   <= 1'b1;
                clk   <= 1'b0;
                mosi  <= 1'b0;
            end else begin
                case (state)
                    ldIdle: begin
                        if (acc.start) begin
                            txReg   <= {bubbleEmuPkg::READ_CMD, startAddr};
                            mosi    <= bubbleEmuPkg::READ_CMD[7];
                            nCs     <= 1'b0;
                            clk     <= 1'b0;
                            bitCnt  <= '0;
                            byteCnt <= '0;
                            state   <= ldCmd;
                        end
                    end
                    ldCmd, ldAddr: begin
                        clk <= !clk;
                        if (clk) begin
                            // Falling edge, next header bit
                            txReg  <= {txReg[30:0], 1'b0};
                            mosi   <= txReg[30];
                            bitCnt <= bitCnt + 5'd1;
                            if (state == ldCmd && bitCnt == 5'd7) begin
                                state  <= ldAddr;
                                bitCnt <= '0;
                            end else if (state == ldAddr && bitCnt == 5'd23) begin
                                state  <= ldData;
                                bitCnt <= '0;
                            end
                        end
                    end
                    ldData: begin
                        clk <= !clk;
                        if (!clk) begin
                            // Rising edge, flash data is stable here
                            rxReg  <= {rxReg[6:0], miso};
                            bitCnt <= bitCnt + 5'd1;
                        end else if (bitCnt == 5'd8) begin
                            wr.en   <= 1'b1;
                            wr.addr <= byteCnt;
                            wr.data <= rxReg;
                            bitCnt  <= '0;
                            byteCnt <= byteCnt + 1'b1;
                            if (byteCnt == bubbleEmuPkg::byteAddr'(bubbleEmuPkg::PAGE_BYTES - 1)) begin
                                state <= ldIdle;
                                nCs   <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= ldIdle;
                        nCs   <= 1'b1;
                        clk   <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- BubbleInterface.sv
`timescale 1ns/1ps
`default_nettype none

module BubbleInterface (
    input  logic                  MCLK,
    input  logic                  rstN,
    input  bubbleEmuPkg::accCtrl  acc,
    input  bubbleEmuPkg::bufWrite wr,
    output logic                  dout0,
    output logic                  dout1,
    output logic                  dout2,
    output logic                  dout3
);

    logic [7:0]            pageBuf [bubbleEmuPkg::PAGE_BYTES];
    bubbleEmuPkg::byteAddr rdAddr;
    logic [7:0]            curByte;
    logic [3:0]            curNibble;
    logic [3:0]            outReg;

    // Page buffer, filled by the loader one byte at a time
    always_ff @(posedge MCLK) begin
        if (wr.en) begin
            pageBuf[wr.addr] <= wr.data;
        end
    end

    // Two nibbles per byte, high one first
    assign rdAddr    = acc.boutCycle[6:1];
    assign curByte   = pageBuf[rdAddr];
    assign curNibble = acc.boutCycle[0] ? curByte[3:0] : curByte[7:4];

    always_ff @(posedge MCLK or negedge rstN) begin
        if (!rstN) begin
            outReg <= '0;
        end else if (acc.state != bubbleEmuPkg::accOut) begin
            outReg <= '0;
        end else if (acc.boutEn) begin
            outReg <= curNibble;
        end
    end

    assign dout0 = outReg[0];
    assign dout1 = outReg[1];
    assign dout2 = outReg[2];
    assign dout3 = outReg[3];

endmodule

`default_nettype wire

//--- BubbleDrive8_emucore.sv
`timescale 1ns/1ps
`default_nettype none

module BubbleDrive8_emucore (
    input  logic                MCLK,
    input  logic                rstN,
    input  logic                nEn,
    input  bubbleEmuPkg::imgSel imgNum,
    output logic                clkOut,
    input  logic                nBss,
    input  logic                nBsen,
    input  logic                nBooten,
    output logic                dout0,
    output logic                dout1,
    output logic                dout2,
    output logic                dout3,
    output logic                nRomCs,
    output logic                romMosi,
    input  logic                romMiso,
    output logic                romClk,
    output logic                nAcc
);

    bubbleEmuPkg::accCtrl  acc;
    bubbleEmuPkg::bufWrite wr;

    // Access LED, lit for the whole load and output phase
    assign nAcc = (acc.state == bubbleEmuPkg::accIdle);

    TimingGenerator TimingGenerator_0 (
        .MCLK    (MCLK   ),
        .rstN    (rstN   ),
        .nEn     (nEn    ),
        .nBss    (nBss   ),
        .nBsen   (nBsen  ),
        .nBooten (nBooten),
        .clkOut  (clkOut ),
        .acc     (acc    )
    );

    SPILoader SPILoader_0 (
        .MCLK   (MCLK   ),
        .rstN   (rstN   ),
        .imgNum (imgNum ),
        .acc    (acc    ),
        .wr     (wr     ),
        .nCs    (nRomCs ),
        .mosi   (romMosi),
        .clk    (romClk ),
        .miso   (romMiso)
    );

    BubbleInterface BubbleInterface_0 (
        .MCLK  (MCLK ),
        .rstN  (rstN ),
        .acc   (acc  ),
        .wr    (wr   ),
        .dout0 (dout0),
        .dout1 (dout1),
        .dout2 (dout2),
        .dout3 (dout3)
    );

endmodule

`default_nettype wire

//--- W25Q32Model.sv
`timescale 1ns/1ps
`default_nettype none

module W25Q32Model (
    input  logic nCs,
    input  logic clk,
    input  logic mosi,
    output logic miso
);

    logic [31:0] header = '0;
    int          rxCount = 0;
    int          dataBit;
    logic [23:0] rdAddr;
    logic [7:0]  rdByte;

    initial begin
        miso = 1'b0;
    end

    // Header is the command byte followed by a 24-bit address
    always @(posedge clk or posedge nCs) begin
        if (nCs) begin
            rxCount <= 0;
        end else begin
            if (rxCount < 32) begin
                header <= {header[30:0], mosi};
            end
            rxCount <= rxCount + 1;
        end
    end

    // Mode 0, data goes out on the falling edge
    always @(negedge clk) begin
        if (!nCs && rxCount >= 32 && header[31:24] == 8'h03) begin
            dataBit = rxCount - 32;
            rdAddr  = header[23:0] + 24'(dataBit / 8);
            rdByte  = rdAddr[7:0] ^ rdAddr[15:8] ^ rdAddr[23:16] ^ 8'h5A;
            miso   <= rdByte[7 - (dataBit % 8)];
        end else begin
            miso <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- BubbleDrive8_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module BubbleDrive8_asserts (
    input logic                 MCLK,
    input logic                 rstN,
    input bubbleEmuPkg::accCtrl acc,
    input logic                 nAcc,
    input logic                 nRomCs
);

    // Output phase never overlaps the flash read
    noOutDuringLoad: assert property (@(posedge MCLK) disable iff (!rstN)
        acc.boutEn |-> nRomCs)
        else $error("boutEn pulsed while the SPI loader was busy");

    startLightsLed: assert property (@(posedge MCLK) disable iff (!rstN)
        acc.start |=> !nAcc)
        else $error("nAcc not low in the cycle after start");

    // One output clock period after the last nibble
    lastNibbleEnds: assert property (@(posedge MCLK) disable iff (!rstN)
        (acc.boutEn && acc.boutCycle == 7'd127) |-> ##12 (acc.state == bubbleEmuPkg::accIdle))
        else $error("access did not return to idle after nibble 127");

endmodule

`default_nettype wire

//--- tb_BubbleDrive8_emucore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_BubbleDrive8_emucore;

    localparam int EDGE_TIMEOUT  = 2 * bubbleEmuPkg::CLK_DIV + 4;
    localparam int START_TIMEOUT = 3 * bubbleEmuPkg::CLK_DIV;

    logic MCLK;
    logic rstN;
    logic nEn;
    logic nBss;
    logic nBsen;
    logic nBooten;
    bubbleEmuPkg::imgSel imgNum;
    logic clkOut;
    logic dout0;
    logic dout1;
    logic dout2;
    logic dout3;
    logic nRomCs;
    logic romMosi;
    logic romMiso;
    logic romClk;
    logic nAcc;

    int errCount = 0;
    int errMark = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int expPos = 0;
    int seed;
    logic [2:0] img;
    bit boot;

    BubbleDrive8_emucore u_BubbleDrive8_emucore (.*);

    W25Q32Model u_flash (.nCs(nRomCs), .clk(romClk), .mosi(romMosi), .miso(romMiso));

    bind TimingGenerator BubbleDrive8_asserts u_asserts (
        .MCLK   (MCLK),
        .rstN   (rstN),
        .acc    (acc),
        .nAcc   (tb_BubbleDrive8_emucore.u_BubbleDrive8_emucore.nAcc),
        .nRomCs (tb_BubbleDrive8_emucore.u_BubbleDrive8_emucore.nRomCs)
    );

    initial begin
        MCLK = 1'b0;
        forever #10 MCLK = ~MCLK;
    end

    // Flash byte is a fold of its address
    // Nibbles go out high first
    function automatic logic [3:0] expNibble(input logic [2:0] imgIn, input int pos,
                                             input bit bootIn, input int k);
        bubbleEmuPkg::flashAddr a;
        logic [7:0] b;
        a = bubbleEmuPkg::flashAddr'(imgIn) * bubbleEmuPkg::IMAGE_STRIDE;
        a = a + (bootIn ? bubbleEmuPkg::BOOT_OFFSET : bubbleEmuPkg::flashAddr'(pos * 64));
        a = a + bubbleEmuPkg::flashAddr'(k / 2);
        b = a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
        return k[0] ? b[3:0] : b[7:4];
    endfunction

    task automatic checkValue(input string name, input logic [3:0] got, input logic [3:0] want);
        assert (got === want) else begin
            $display("ERROR %s: expected %h, got %h", name, want, got);
            errCount++;
        end
    endtask

    task automatic waitClkEdge(input logic level, output bit ok);
        logic prev;
        int n;
        prev = clkOut;
        ok = 1'b0;
        n = 0;
        while (!ok && n < EDGE_TIMEOUT) begin
            @(negedge MCLK);
            n++;
            ok = (clkOut === level && prev !== level);
            prev = clkOut;
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (8) @(negedge MCLK);
        rstN = 1'b1;
        expPos = 0;
    endtask

    task automatic stepPositions(input int n);
        bit ok;
        int i;
        nBss = 1'b0;
        for (i = 0; i < n; i++) begin
            waitClkEdge(1'b1, ok);
            if (!ok) begin
                $display("TIMEOUT clkOut stopped toggling while stepping the position");
                errCount++;
                break;
            end
        end
        nBss = 1'b1;
        expPos = (expPos + n) % bubbleEmuPkg::PAGE_COUNT;
    endtask

    task automatic startRead(input bit bootIn);
        int n;
        nBsen = 1'b0;
        nBooten = !bootIn;
        n = 0;
        while (nAcc !== 1'b0 && n < START_TIMEOUT) begin
            @(negedge MCLK);
            n++;
        end
        nBsen = 1'b1;
        nBooten = 1'b1;
    endtask

    // Counts output clock rises from the start tick and samples each nibble
    task automatic checkPage(input logic [2:0] imgIn, input int pos, input bit bootIn);
        bit ok;
        int n;
        int k;
        ok = 1'b0;
        n = 0;
        while (!ok && n < START_TIMEOUT) begin
            @(negedge MCLK);
            n++;
            ok = (nAcc === 1'b0);
        end
        if (!ok) begin
            $display("TIMEOUT nAcc never went low after the read request");
            errCount++;
            return;
        end
        for (k = 0; k < bubbleEmuPkg::LOAD_WAIT && ok; k++) begin
            waitClkEdge(1'b1, ok);
        end
        for (k = 0; k < bubbleEmuPkg::NIBBLE_COUNT && ok; k++) begin
            if (k > 0) begin
                waitClkEdge(1'b1, ok);
            end
            if (ok) begin
                waitClkEdge(1'b0, ok);
            end
            if (ok) begin
                checkValue($sformatf("dout[3:0] nibble %0d", k), {dout3, dout2, dout1, dout0},
                           expNibble(imgIn, pos, bootIn, k));
            end
        end
        if (!ok) begin
            $display("TIMEOUT clkOut stopped toggling during the access");
            errCount++;
            return;
        end
        n = 0;
        while (nAcc !== 1'b1 && n < START_TIMEOUT) begin
            @(negedge MCLK);
            n++;
        end
        @(negedge MCLK);
        checkValue("nAcc", {3'b0, nAcc}, 4'h1);
        checkValue("dout[3:0] after access", {dout3, dout2, dout1, dout0}, 4'h0);
    endtask

    task automatic readAndCheck(input logic [2:0] imgIn, input bit bootIn);
        int pos;
        pos = expPos;
        imgNum = imgIn;
        fork
            startRead(bootIn);
            checkPage(imgIn, pos, bootIn);
        join
    endtask

    task automatic finishTest(input string name);
        if (errCount == errMark) begin
            testsPassed++;
            $display("PASS %s", name);
        end else begin
            testsFailed++;
            $display("FAIL %s with %0d errors", name, errCount - errMark);
        end
        errMark = errCount;
    endtask

    initial begin
        seed = 32'h4369f1f1;
        void'($urandom(seed));
        nEn = 1'b0;
        nBss = 1'b1;
        nBsen = 1'b1;
        nBooten = 1'b1;
        imgNum = '0;
        applyReset();
        checkValue("clkOut", {3'b0, clkOut}, 4'h0);
        checkValue("nAcc", {3'b0, nAcc}, 4'h1);
        checkValue("nRomCs", {3'b0, nRomCs}, 4'h1);
        checkValue("romClk", {3'b0, romClk}, 4'h0);
        checkValue("dout[3:0]", {dout3, dout2, dout1, dout0}, 4'h0);
        finishTest("reset state");

        stepPositions(int'($urandom_range(40, 1)));
        readAndCheck(3'd1, 1'b0);
        finishTest("normal read");

        stepPositions(int'($urandom_range(40, 1)));
        readAndCheck(3'd5, 1'b1);
        finishTest("boot read");

        applyReset();
        stepPositions(2050);
        readAndCheck(3'd2, 1'b0);
        finishTest("position wrap");

        nEn = 1'b1;
        @(negedge MCLK);
        for (int i = 0; i < 60; i++) begin
            @(negedge MCLK);
            nBsen = (i >= 10 && i < 40) ? 1'b0 : 1'b1;
            checkValue("clkOut", {3'b0, clkOut}, 4'h0);
            checkValue("nAcc", {3'b0, nAcc}, 4'h1);
            checkValue("nRomCs", {3'b0, nRomCs}, 4'h1);
        end
        nBsen = 1'b1;
        nEn = 1'b0;
        expPos = 0;
        finishTest("disable");

        for (int r = 0; r < 6; r++) begin
            img = 3'($urandom_range(7, 0));
            boot = 1'($urandom_range(1, 0));
            stepPositions(int'($urandom_range(40, 1)));
            readAndCheck(img, boot);
        end
        finishTest("random sweep");

        $display("%0d run, %0d passed, %0d failed, %0d errors",
                 testsPassed + testsFailed, testsPassed, testsFailed, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
bubbleEmuPkg.sv
TimingGenerator.sv
SPILoader.sv
BubbleInterface.sv
BubbleDrive8_emucore.sv
W25Q32Model.sv
BubbleDrive8_asserts.sv
tb_BubbleDrive8_emucore.sv

//--- Makefile
TOP := tb_BubbleDrive8_emucore

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "^all tests passed$$" sim.log; then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
